// ==== exec_alu.sv ====
module exec_alu import exec_pkg::*; (
  input  alu_op_e alu_op,
  input  logic    use_carry,
  input  logic    src_inv,
  input  logic    src_inc,
  input  logic    clear_cf_of,
  input  word_t   flags_in,
  input  word_t   a,
  input  word_t   b,
  output word_t   result,
  output word_t   flags_out
);

  word_t       b_eff;
  logic        cin;
  logic [32:0] sum;
  logic [4:0]  shamt;
  logic [32:0] shl_wide;
  logic [32:0] shr_wide;
  logic        cf;
  logic        of;
  logic        shift_zero;

  // Adder with optional source inversion and carry in
  assign b_eff = src_inv ? ~b : b;
  // SBB needs the inverted carry as its borrow term
  assign cin   = use_carry ? (flags_in[FLAG_CF] ^ src_inv) : src_inc;
  assign sum   = {1'b0, a} + {1'b0, b_eff} + {32'h0, cin};

  // Shifts keep one extra bit for the last bit shifted out
  assign shamt    = b[4:0];
  assign shl_wide = {1'b0, a} << shamt;
  assign shr_wide = {a, 1'b0} >> shamt;

  // Zero count shifts leave every flag alone
  assign shift_zero = ((alu_op == ALU_SHL) || (alu_op == ALU_SHR)) && (shamt == '0);

  always_comb begin
    result = a;
    cf     = flags_in[FLAG_CF];
    of     = flags_in[FLAG_OF];
    case (alu_op)
      ALU_ADD, ALU_SUB: begin
        result = sum[31:0];
        // Borrow is the inverted carry for subtraction
        cf     = sum[32] ^ src_inv;
        of     = (a[31] == b_eff[31]) && (sum[31] != a[31]);
      end
      ALU_AND: result = a & b;
      ALU_OR:  result = a | b;
      ALU_XOR: result = a ^ b;
      ALU_SHL: begin
        result = shl_wide[31:0];
        cf     = shl_wide[32];
        of     = shl_wide[32] ^ shl_wide[31];
      end
      ALU_SHR: begin
        result = shr_wide[32:1];
        cf     = shr_wide[0];
        of     = a[31];
      end
      ALU_PASS: result = src_inv ? ~a : a;
      default:  result = a;
    endcase
    // Logic ops force CF and OF low
    if (clear_cf_of) begin
      cf = 1'b0;
      of = 1'b0;
    end
  end

  // Status merge, all other EFLAGS bits pass through
  always_comb begin
    flags_out = flags_in;
    if (!shift_zero) begin
      flags_out[FLAG_CF] = cf;
      flags_out[FLAG_PF] = ~^result[7:0];  // even parity of low byte
      flags_out[FLAG_ZF] = (result == '0);
      flags_out[FLAG_SF] = result[31];
      flags_out[FLAG_OF] = of;
    end
  end

endmodule

// ==== exec_cfu.sv ====
module exec_cfu import exec_pkg::*; (
  input  opcode_e opcode,
  input  word_t   eflags,
  input  logic    ecx_zero,
  input  word_t   eip,
  input  ilen_t   ilen,
  input  word_t   target,
  output word_t   next_eip
);

  word_t fall_thru;
  logic  taken;

  // Sequential successor
  assign fall_thru = eip + word_t'(ilen);

  // Branch condition per opcode
  always_comb begin
    case (opcode)
      OP_JMP:  taken = 1'b1;
      OP_JZ:   taken = eflags[FLAG_ZF];
      OP_JNZ:  taken = !eflags[FLAG_ZF];
      OP_JC:   taken = eflags[FLAG_CF];
      OP_JCXZ: taken = ecx_zero;
      default: taken = 1'b0;
    endcase
  end

  // Target comes in through opnd0
  assign next_eip = taken ? target : fall_thru;

endmodule

// ==== exec_issue.sv ====
module exec_issue import exec_pkg::*; #(
  parameter int IN_DEPTH  = 4,
  parameter int RET_DEPTH = 4
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  exec_req_t in_req,
  output logic      in_credit,
  input  logic      ret_credit,
  output logic      iss_valid,
  output issue_t    iss_data
);

  localparam int PW = (IN_DEPTH > 1) ? $clog2(IN_DEPTH) : 1;
  localparam int CW = $clog2(IN_DEPTH + 1);
  localparam int RW = $clog2(RET_DEPTH + 1);

  // Input FIFO payload
  exec_req_t     mem [IN_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] fill;
  // Free result slots reserved in retire
  logic [RW-1:0] ret_cnt;
  logic          pop;
  exec_req_t     head;
  uop_t          uop;

  assign head = mem[rd_ptr];

  // Pop only while a result slot is held
  assign pop = (fill != '0) && (ret_cnt != '0);

  // Every entry leaving frees one upstream credit
  assign in_credit = pop;

  // Upstream never writes without a credit, so no full check
  always_ff @(posedge clk) begin
    if (in_valid) begin
      mem[wr_ptr] <= in_req;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr  <= '0;
      rd_ptr  <= '0;
      fill    <= '0;
      ret_cnt <= RW'(RET_DEPTH);
    end else begin
      if (in_valid) begin
        wr_ptr <= (wr_ptr == PW'(IN_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(IN_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill    <= fill + CW'(in_valid) - CW'(pop);
      // Spend on pop, refund when retire lets a result go
      ret_cnt <= ret_cnt + RW'(ret_credit) - RW'(pop);
    end
  end

  // Opcode decode of the FIFO head
  always_comb begin
    uop        = '0;
    uop.unit   = UNIT_NONE;
    uop.alu_op = ALU_PASS;
    uop.opcode = head.opcode;
    uop.tag    = head.tag;
    case (head.opcode)
      // INC and DEC get the constant 1 in opnd1_r from decode
      OP_ADD, OP_INC: begin
        uop.unit   = UNIT_ALU;
        uop.alu_op = ALU_ADD;
      end
      OP_ADC: begin
        uop.unit      = UNIT_ALU;
        uop.alu_op    = ALU_ADD;
        uop.use_carry = 1'b1;
      end
      OP_SUB, OP_DEC, OP_CMP, OP_PUSH: begin
        uop.unit         = UNIT_ALU;
        uop.alu_op       = ALU_SUB;
        uop.src_inc      = 1'b1;
        uop.no_wr        = (head.opcode == OP_CMP);
        uop.no_flags     = (head.opcode == OP_PUSH);
        uop.stack_adjust = (head.opcode == OP_PUSH);
      end
      OP_SBB: begin
        uop.unit      = UNIT_ALU;
        uop.alu_op    = ALU_SUB;
        uop.use_carry = 1'b1;
      end
      OP_AND, OP_TEST: begin
        uop.unit        = UNIT_ALU;
        uop.alu_op      = ALU_AND;
        uop.clear_cf_of = 1'b1;
        uop.no_wr       = (head.opcode == OP_TEST);
      end
      OP_OR, OP_XOR: begin
        uop.unit        = UNIT_ALU;
        uop.alu_op      = (head.opcode == OP_OR) ? ALU_OR : ALU_XOR;
        uop.clear_cf_of = 1'b1;
      end
      // Inversion of opnd0 happens in the pass path
      OP_NOT: begin
        uop.unit     = UNIT_ALU;
        uop.no_flags = 1'b1;
      end
      OP_SHL, OP_SHR: begin
        uop.unit   = UNIT_ALU;
        uop.alu_op = (head.opcode == OP_SHL) ? ALU_SHL : ALU_SHR;
      end
      OP_POP: begin
        uop.unit         = UNIT_ALU;
        uop.alu_op       = ALU_ADD;
        uop.no_flags     = 1'b1;
        uop.stack_adjust = 1'b1;
      end
      OP_MOV, OP_MOVZX8, OP_MOVSX8, OP_XCHG: begin
        uop.unit = UNIT_MOVE;
        uop.zext = (head.opcode == OP_MOVZX8);
        uop.sext = (head.opcode == OP_MOVSX8);
        uop.swap = (head.opcode == OP_XCHG);
      end
      OP_STC, OP_CLC, OP_STD, OP_CLD: uop.unit = UNIT_META;
      // Jumps and NOP only touch EIP
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      iss_valid <= 1'b0;
    end else begin
      iss_valid <= pop;
    end
  end

  // Issue payload
  always_ff @(posedge clk) begin
    if (pop) begin
      iss_data.uop      <= uop;
      iss_data.eflags   <= head.eflags;
      iss_data.ecx_zero <= head.ecx_zero;
      iss_data.eip      <= head.eip;
      iss_data.ilen     <= head.ilen;
      iss_data.opnd0_r  <= head.opnd0_r;
      iss_data.opnd1_r  <= head.opnd1_r;
      iss_data.opnd2_r  <= head.opnd2_r;
    end
  end

endmodule

// ==== exec_pipe.f ====
exec_pkg.sv
exec_alu.sv
exec_cfu.sv
exec_issue.sv
exec_stage.sv
exec_retire.sv
exec_pipe.sv
tb_clk_gen.sv
exec_pipe_asserts.sv
exec_pipe_tb.sv

// ==== exec_pipe.sv ====
module exec_pipe import exec_pkg::*; #(
  parameter int IN_DEPTH  = 4,
  parameter int RET_DEPTH = 4
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      in_valid,
  input  exec_req_t in_req,
  output logic      in_credit,
  output logic      out_valid,
  output exec_res_t out_res,
  input  logic      out_credit
);

  // Issue to execute
  logic      iss_valid;
  issue_t    iss_data;
  // Execute to retire
  logic      ex_valid;
  exec_res_t ex_res;
  // Result slot returned to issue
  logic      ret_credit;

  exec_issue #(
    .IN_DEPTH  (IN_DEPTH),
    .RET_DEPTH (RET_DEPTH)
  ) i_exec_issue (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_credit  (in_credit),
    .ret_credit (ret_credit),
    .iss_valid  (iss_valid),
    .iss_data   (iss_data)
  );

  exec_stage i_exec_stage (
    .clk       (clk),
    .arst_n    (arst_n),
    .iss_valid (iss_valid),
    .iss_data  (iss_data),
    .ex_valid  (ex_valid),
    .ex_res    (ex_res)
  );

  exec_retire #(
    .RET_DEPTH (RET_DEPTH)
  ) i_exec_retire (
    .clk        (clk),
    .arst_n     (arst_n),
    .ex_valid   (ex_valid),
    .ex_res     (ex_res),
    .ret_credit (ret_credit),
    .out_valid  (out_valid),
    .out_res    (out_res),
    .out_credit (out_credit)
  );

endmodule

// ==== exec_pipe_asserts.sv ====
module exec_pipe_asserts #(
  parameter int IN_DEPTH  = 4,
  parameter int RET_DEPTH = 4
) (
  input logic                           clk,
  input logic                           arst_n,
  input logic                           in_valid,
  input logic                           in_credit,
  input logic                           out_valid,
  input logic                           out_credit,
  input logic                           ex_valid,
  input logic [$clog2(RET_DEPTH+1)-1:0] ret_cnt
);
  timeunit 1ns;
  timeprecision 100ps;

  // Credits the upstream holds
  int up_cnt;
  // Credits granted on out_credit and not yet spent
  int dn_cnt;
  // Number of failed assertions, watched by the testbench
  int fail_cnt = 0;

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      up_cnt <= IN_DEPTH;
      dn_cnt <= 0;
    end else begin
      up_cnt <= up_cnt + int'(in_credit) - int'(in_valid);
      dn_cnt <= dn_cnt + int'(out_credit) - int'(out_valid);
    end
  end

  // Downstream credit must be held for every result
  a_out_credit: assert property (@(posedge clk) disable iff (!arst_n)
    out_valid |-> (dn_cnt > 0))
    else begin
      $error("out_valid with zero downstream credit");
      fail_cnt++;
    end

  // Upstream writes only with a credit in hand
  a_in_credit: assert property (@(posedge clk) disable iff (!arst_n)
    in_valid |-> (up_cnt > 0))
    else begin
      $error("in_valid without an upstream credit");
      fail_cnt++;
    end

  // Issue never holds more result slots than retire has
  a_ret_range: assert property (@(posedge clk) disable iff (!arst_n)
    ret_cnt <= RET_DEPTH)
    else begin
      $error("internal credit count above RET_DEPTH");
      fail_cnt++;
    end

  // Links stay idle in reset
  a_reset_idle: assert property (@(posedge clk)
    !arst_n |-> (!in_credit && !out_valid && !ex_valid))
    else begin
      $error("credit or valid active during reset");
      fail_cnt++;
    end

endmodule

bind exec_pipe exec_pipe_asserts #(
  .IN_DEPTH  (IN_DEPTH),
  .RET_DEPTH (RET_DEPTH)
) i_exec_pipe_asserts (
  .clk        (clk),
  .arst_n     (arst_n),
  .in_valid   (in_valid),
  .in_credit  (in_credit),
  .out_valid  (out_valid),
  .out_credit (out_credit),
  .ex_valid   (ex_valid),
  .ret_cnt    (i_exec_issue.ret_cnt)
);

// ==== exec_pipe_tb.sv ====
module exec_pipe_tb import exec_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int    IN_DEPTH  = 4;
  localparam int    RET_DEPTH = 4;
  localparam int    NROWS     = 38;
  localparam int    TIMEOUT   = 40 * NROWS + 100;
  // Cycles without downstream credit so that every queue fills
  localparam int    STARVE    = 40;
  localparam word_t SEED      = 32'h234a_7550;

  // One instruction with its expected result
  typedef struct packed {
    opcode_e op;
    word_t   opnd0;
    word_t   opnd1;
    word_t   opnd2;
    word_t   eflags;
    word_t   eip;
    ilen_t   ilen;
    logic    ecx_zero;
    word_t   exp_opnd0;
    word_t   exp_opnd1;
    word_t   exp_eflags;
    word_t   exp_next_eip;
  } vec_t;

  // Fields: op, opnd0..2, eflags, eip, ilen, ecx_zero, then opnd0_w, opnd1_w, eflags, next_eip
  localparam vec_t VECS [NROWS] = '{
    // Add family
    '{OP_ADD, 32'h0000_0005, 32'h0000_0003, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0008, 32'h0000_0003, 32'h202, 32'h1002},
    '{OP_ADD, 32'h7FFF_FFFF, 32'h0000_0001, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h8000_0000, 32'h0000_0001, 32'hA86, 32'h1002},
    '{OP_ADD, 32'hFFFF_FFFF, 32'h0000_0001, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0000, 32'h0000_0001, 32'h247, 32'h1002},
    '{OP_ADC, 32'h0000_0010, 32'h0000_0020, 32'h0, 32'h203, 32'h1000, 4'd2, 1'b0,
      32'h0000_0031, 32'h0000_0020, 32'h202, 32'h1002},
    '{OP_INC, 32'h0000_00FF, 32'h0000_0001, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0100, 32'h0000_0001, 32'h206, 32'h1002},
    // Subtract family, CF is the borrow
    '{OP_SUB, 32'h0000_0005, 32'h0000_0007, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'hFFFF_FFFE, 32'h0000_0007, 32'h283, 32'h1002},
    '{OP_SUB, 32'h8000_0000, 32'h0000_0001, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h7FFF_FFFF, 32'h0000_0001, 32'hA06, 32'h1002},
    '{OP_SBB, 32'h0000_0010, 32'h0000_0005, 32'h0, 32'h203, 32'h1000, 4'd2, 1'b0,
      32'h0000_000A, 32'h0000_0005, 32'h206, 32'h1002},
    '{OP_DEC, 32'h0000_0001, 32'h0000_0001, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0000, 32'h0000_0001, 32'h246, 32'h1002},
    '{OP_CMP, 32'h0000_1234, 32'h0000_1234, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_1234, 32'h0000_1234, 32'h246, 32'h1002},
    '{OP_CMP, 32'h0000_0003, 32'h0000_0004, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0003, 32'h0000_0004, 32'h287, 32'h1002},
    // Logic ops clear CF and OF
    '{OP_AND, 32'hF0F0_00FF, 32'h0FF0_0F0F, 32'h0, 32'hA03, 32'h1000, 4'd2, 1'b0,
      32'h00F0_000F, 32'h0FF0_0F0F, 32'h206, 32'h1002},
    '{OP_OR, 32'h8000_0000, 32'h0000_0001, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h8000_0001, 32'h0000_0001, 32'h282, 32'h1002},
    '{OP_XOR, 32'hDEAD_BEEF, 32'hDEAD_BEEF, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0000, 32'hDEAD_BEEF, 32'h246, 32'h1002},
    '{OP_NOT, 32'h0F0F_00FF, 32'h0000_1234, 32'h0, 32'hA43, 32'h1000, 4'd2, 1'b0,
      32'hF0F0_FF00, 32'h0000_1234, 32'hA43, 32'h1002},
    '{OP_TEST, 32'h0000_0080, 32'h0000_00F0, 32'h0, 32'h803, 32'h1000, 4'd2, 1'b0,
      32'h0000_0080, 32'h0000_00F0, 32'h002, 32'h1002},
    // Shift count 0x21 uses only its low 5 bits
    '{OP_SHL, 32'h8000_0001, 32'h0000_0021, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0002, 32'h0000_0021, 32'hA03, 32'h1002},
    '{OP_SHR, 32'h0000_0013, 32'h0000_0002, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h0000_0004, 32'h0000_0002, 32'h203, 32'h1002},
    // Stack adjust on opnd1 with step opnd2
    '{OP_PUSH, 32'hCAFE_0000, 32'h0000_2000, 32'h4, 32'h202, 32'h1000, 4'd1, 1'b0,
      32'hCAFE_0000, 32'h0000_1FFC, 32'h202, 32'h1001},
    '{OP_POP, 32'h5555_AAAA, 32'h0000_1FFC, 32'h4, 32'hA47, 32'h1000, 4'd1, 1'b0,
      32'h5555_AAAA, 32'h0000_2000, 32'hA47, 32'h1001},
    // Moves
    '{OP_MOV, 32'h1111_1111, 32'h2222_3333, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'h2222_3333, 32'h2222_3333, 32'h202, 32'h1002},
    '{OP_MOVZX8, 32'h0000_0000, 32'hABCD_EF85, 32'h0, 32'h202, 32'h1000, 4'd3, 1'b0,
      32'h0000_0085, 32'hABCD_EF85, 32'h202, 32'h1003},
    '{OP_MOVSX8, 32'h0000_0000, 32'h0000_0085, 32'h0, 32'h202, 32'h1000, 4'd3, 1'b0,
      32'hFFFF_FF85, 32'h0000_0085, 32'h202, 32'h1003},
    '{OP_XCHG, 32'hAAAA_0001, 32'hBBBB_0002, 32'h0, 32'h202, 32'h1000, 4'd2, 1'b0,
      32'hBBBB_0002, 32'hAAAA_0001, 32'h202, 32'h1002},
    // Flag set and clear
    '{OP_STC, 32'h0000_0011, 32'h0000_0022, 32'h0, 32'h202, 32'h1000, 4'd1, 1'b0,
      32'h0000_0011, 32'h0000_0022, 32'h203, 32'h1001},
    '{OP_CLC, 32'h0000_0011, 32'h0000_0022, 32'h0, 32'hA47, 32'h1000, 4'd1, 1'b0,
      32'h0000_0011, 32'h0000_0022, 32'hA46, 32'h1001},
    '{OP_STD, 32'h0000_0011, 32'h0000_0022, 32'h0, 32'h203, 32'h1000, 4'd1, 1'b0,
      32'h0000_0011, 32'h0000_0022, 32'h603, 32'h1001},
    '{OP_CLD, 32'h0000_0011, 32'h0000_0022, 32'h0, 32'h6C2, 32'h1000, 4'd1, 1'b0,
      32'h0000_0011, 32'h0000_0022, 32'h2C2, 32'h1001},
    // Jumps, target in opnd0
    '{OP_JMP, 32'h0000_4000, 32'h0, 32'h0, 32'h202, 32'h1000, 4'd5, 1'b0,
      32'h0000_4000, 32'h0, 32'h202, 32'h4000},
    '{OP_JZ, 32'h0000_2000, 32'h0, 32'h0, 32'h242, 32'h1010, 4'd2, 1'b0,
      32'h0000_2000, 32'h0, 32'h242, 32'h2000},
    '{OP_JZ, 32'h0000_2000, 32'h0, 32'h0, 32'h202, 32'h1010, 4'd2, 1'b0,
      32'h0000_2000, 32'h0, 32'h202, 32'h1012},
    '{OP_JNZ, 32'h0000_3000, 32'h0, 32'h0, 32'h202, 32'h1020, 4'd2, 1'b0,
      32'h0000_3000, 32'h0, 32'h202, 32'h3000},
    '{OP_JNZ, 32'h0000_3000, 32'h0, 32'h0, 32'h242, 32'h1020, 4'd2, 1'b0,
      32'h0000_3000, 32'h0, 32'h242, 32'h1022},
    '{OP_JC, 32'h0000_5000, 32'h0, 32'h0, 32'h203, 32'h1030, 4'd6, 1'b0,
      32'h0000_5000, 32'h0, 32'h203, 32'h5000},
    '{OP_JC, 32'h0000_5000, 32'h0, 32'h0, 32'h202, 32'h1030, 4'd6, 1'b0,
      32'h0000_5000, 32'h0, 32'h202, 32'h1036},
    '{OP_JCXZ, 32'h0000_6000, 32'h0, 32'h0, 32'h202, 32'h1040, 4'd2, 1'b1,
      32'h0000_6000, 32'h0, 32'h202, 32'h6000},
    '{OP_JCXZ, 32'h0000_6000, 32'h0, 32'h0, 32'h202, 32'h1040, 4'd2, 1'b0,
      32'h0000_6000, 32'h0, 32'h202, 32'h1042},
    // EIP wraps past the top
    '{OP_NOP, 32'h0000_0077, 32'h0000_0088, 32'h0, 32'h202, 32'hFFFF_FFFE, 4'd3, 1'b0,
      32'h0000_0077, 32'h0000_0088, 32'h202, 32'h0000_0001}
  };

  logic      clk;
  logic      arst_n;
  logic      in_valid;
  exec_req_t in_req;
  logic      in_credit;
  logic      out_valid;
  exec_res_t out_res;
  logic      out_credit;

  word_t lfsr;
  // Driver side counts
  int    sent = 0;
  // Monitor side counts
  int    returned = 0;
  int    granted  = 0;
  int    rx_cnt   = 0;
  int    cycles   = 0;

  tb_clk_gen #(
    .PERIOD_NS  (8),
    .RST_CYCLES (5)
  ) i_tb_clk_gen (
    .clk    (clk),
    .arst_n (arst_n)
  );

  exec_pipe #(
    .IN_DEPTH  (IN_DEPTH),
    .RET_DEPTH (RET_DEPTH)
  ) i_exec_pipe (
    .clk        (clk),
    .arst_n     (arst_n),
    .in_valid   (in_valid),
    .in_req     (in_req),
    .in_credit  (in_credit),
    .out_valid  (out_valid),
    .out_res    (out_res),
    .out_credit (out_credit)
  );

  // Galois LFSR, x^32 + x^22 + x^2 + x + 1
  function automatic word_t lfsr_next(input word_t s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  task automatic random_bit(output logic b);
    b    = lfsr[0];
    lfsr = lfsr_next(lfsr);
  endtask

  task automatic abort_run(input string why);
    $display("TEST FAIL");
    $fatal(1, "%s", why);
  endtask

  task automatic check_word(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
      abort_run("result value mismatch");
    end
  endtask

  task automatic check_tag(input string name, input tag_t got, input tag_t exp);
    if (got !== exp) begin
      $display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
      abort_run("result out of order");
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge clk) begin
    if (i_exec_pipe.i_exec_pipe_asserts.fail_cnt != 0) begin
      abort_run("a credit link assertion failed");
    end
    if (arst_n) begin
      cycles++;
      if (cycles > TIMEOUT) begin
        abort_run("timeout, not all results arrived");
      end
      if (in_credit) begin
        returned++;
      end
      if (out_valid) begin
        if (rx_cnt >= NROWS) begin
          abort_run("result seen after the last request");
        end
        if (rx_cnt >= granted) begin
          abort_run("result sent without a downstream credit");
        end
        check_tag("out_res.tag", out_res.tag, tag_t'(rx_cnt));
        check_word("out_res.opnd0_w", out_res.opnd0_w, VECS[rx_cnt].exp_opnd0);
        check_word("out_res.opnd1_w", out_res.opnd1_w, VECS[rx_cnt].exp_opnd1);
        check_word("out_res.eflags", out_res.eflags, VECS[rx_cnt].exp_eflags);
        check_word("out_res.next_eip", out_res.next_eip, VECS[rx_cnt].exp_next_eip);
        rx_cnt++;
      end
      // Grant counts from the next cycle on
      if (out_credit) begin
        granted++;
      end
    end
  end

  initial begin : stimulus
    logic send_bit;
    logic grant_a;
    logic grant_b;
    int   cyc;
    in_valid   = 1'b0;
    in_req     = '0;
    out_credit = 1'b0;
    lfsr       = SEED;
    cyc        = 0;
    // Start only once reset has really been applied and released
    wait (arst_n === 1'b0);
    @(posedge arst_n);
    while (rx_cnt < NROWS) begin
      @(posedge clk);
      #1;
      cyc++;
      in_valid   = 1'b0;
      out_credit = 1'b0;
      // Random input gaps, only while a credit is held
      random_bit(send_bit);
      if (send_bit && (sent < NROWS) && (IN_DEPTH + returned - sent > 0)) begin
        in_req.opcode   = VECS[sent].op;
        in_req.tag      = tag_t'(sent);
        in_req.eflags   = VECS[sent].eflags;
        in_req.ecx_zero = VECS[sent].ecx_zero;
        in_req.eip      = VECS[sent].eip;
        in_req.ilen     = VECS[sent].ilen;
        in_req.opnd0_r  = VECS[sent].opnd0;
        in_req.opnd1_r  = VECS[sent].opnd1;
        in_req.opnd2_r  = VECS[sent].opnd2;
        in_valid        = 1'b1;
        sent++;
      end
      // Sparse grants after the starved start
      if (cyc > STARVE) begin
        random_bit(grant_a);
        random_bit(grant_b);
        out_credit = grant_a & grant_b;
      end
    end
    // Spare credits expose any extra result
    repeat (10) begin
      @(posedge clk);
      #1;
      in_valid   = 1'b0;
      out_credit = 1'b1;
    end
    @(posedge clk);
    #1;
    out_credit = 1'b0;
    repeat (2) @(posedge clk);
    if ((i_exec_pipe.i_exec_pipe_asserts.fail_cnt != 0) || (returned != NROWS)) begin
      $display("TEST FAIL");
      $fatal(1, "upstream credits not all returned or an assertion failed");
    end else begin
      $display("TEST PASS");
      $finish;
    end
  end

endmodule

// ==== exec_pkg.sv ====
package exec_pkg;

  // Data word for operands, EIP and EFLAGS
  typedef logic [31:0] word_t;
  // Instruction length in bytes
  typedef logic [3:0] ilen_t;
  // Identifier that travels with each instruction
  typedef logic [7:0] tag_t;

  // EFLAGS bit positions
  localparam int unsigned FLAG_CF = 0;
  localparam int unsigned FLAG_PF = 2;
  localparam int unsigned FLAG_ZF = 6;
  localparam int unsigned FLAG_SF = 7;
  localparam int unsigned FLAG_DF = 10;
  localparam int unsigned FLAG_OF = 11;

  // Decoded instruction opcodes
  typedef enum logic [5:0] {
    OP_NOP, OP_ADD, OP_ADC, OP_INC, OP_SUB, OP_SBB, OP_DEC, OP_CMP,
    OP_AND, OP_OR, OP_XOR, OP_NOT, OP_TEST, OP_SHL, OP_SHR,
    OP_PUSH, OP_POP,
    OP_MOV, OP_MOVZX8, OP_MOVSX8, OP_XCHG,
    OP_STC, OP_CLC, OP_STD, OP_CLD,
    OP_JMP, OP_JZ, OP_JNZ, OP_JC, OP_JCXZ
  } opcode_e;

  // Core ALU operations
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_SHL, ALU_SHR, ALU_PASS
  } alu_op_e;

  // Path that owns the write operands and flags
  typedef enum logic [2:0] {
    UNIT_ALU, UNIT_MOVE, UNIT_META, UNIT_NONE
  } unit_e;

  // Decoded control word
  typedef struct packed {
    unit_e   unit;
    alu_op_e alu_op;
    logic    use_carry;
    logic    src_inc;
    logic    no_wr;
    logic    no_flags;
    logic    clear_cf_of;
    logic    stack_adjust;
    logic    sext;
    logic    zext;
    logic    swap;
    opcode_e opcode;
    tag_t    tag;
  } uop_t;

  // Request from upstream
  typedef struct packed {
    opcode_e opcode;
    tag_t    tag;
    word_t   eflags;
    logic    ecx_zero;
    word_t   eip;
    ilen_t   ilen;
    word_t   opnd0_r;
    word_t   opnd1_r;
    word_t   opnd2_r;
  } exec_req_t;

  // Issue beat into the execute stage
  typedef struct packed {
    uop_t  uop;
    word_t eflags;
    logic  ecx_zero;
    word_t eip;
    ilen_t ilen;
    word_t opnd0_r;
    word_t opnd1_r;
    word_t opnd2_r;
  } issue_t;

  // Result toward downstream
  typedef struct packed {
    tag_t  tag;
    word_t opnd0_w;
    word_t opnd1_w;
    word_t eflags;
    word_t next_eip;
  } exec_res_t;

endpackage

// ==== exec_retire.sv ====
module exec_retire import exec_pkg::*; #(
  parameter int RET_DEPTH = 4
) (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      ex_valid,
  input  exec_res_t ex_res,
  output logic      ret_credit,
  output logic      out_valid,
  output exec_res_t out_res,
  input  logic      out_credit
);

  localparam int PW = (RET_DEPTH > 1) ? $clog2(RET_DEPTH) : 1;
  localparam int CW = $clog2(RET_DEPTH + 1);
  // Downstream holds at most 255 credits at once
  localparam int DW = 8;

  // Result FIFO payload
  exec_res_t     mem [RET_DEPTH];
  logic [PW-1:0] wr_ptr;
  logic [PW-1:0] rd_ptr;
  logic [CW-1:0] fill;
  logic [DW-1:0] dn_cnt;
  logic          empty;
  logic          wr;
  logic          pop;

  assign empty = (fill == '0);

  // Empty FIFO lets the fresh result leave in the cycle it arrives
  assign out_valid = (!empty || ex_valid) && (dn_cnt != '0);
  assign out_res   = empty ? ex_res : mem[rd_ptr];

  // Head leaves from the FIFO, or the bypassed result skips it
  assign pop = out_valid && !empty;
  assign wr  = ex_valid && !(out_valid && empty);

  // Slot freed toward issue
  assign ret_credit = out_valid;

  // Issue credits keep the FIFO from overflowing
  always_ff @(posedge clk) begin
    if (wr) begin
      mem[wr_ptr] <= ex_res;
    end
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      fill   <= '0;
      dn_cnt <= '0;
    end else begin
      if (wr) begin
        wr_ptr <= (wr_ptr == PW'(RET_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= (rd_ptr == PW'(RET_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      fill   <= fill + CW'(wr) - CW'(pop);
      // One credit per grant pulse, one spent per result
      dn_cnt <= dn_cnt + DW'(out_credit) - DW'(out_valid);
    end
  end

endmodule

// ==== exec_stage.sv ====
module exec_stage import exec_pkg::*; (
  input  logic      clk,
  input  logic      arst_n,
  input  logic      iss_valid,
  input  issue_t    iss_data,
  output logic      ex_valid,
  output exec_res_t ex_res
);

  uop_t  uop;
  word_t alu_a;
  word_t alu_b;
  word_t alu_result;
  word_t alu_flags;
  logic  src_inv;
  word_t mv_opnd0;
  word_t mv_opnd1;
  word_t meta_eflags;
  word_t next_eip;
  word_t opnd0_w;
  word_t opnd1_w;
  word_t eflags_w;

  assign uop = iss_data.uop;

  // Stack adjust runs on the pointer in opnd1 and the step in opnd2
  assign alu_a = uop.stack_adjust ? iss_data.opnd1_r : iss_data.opnd0_r;
  assign alu_b = uop.stack_adjust ? iss_data.opnd2_r : iss_data.opnd1_r;

  // Subtract inverts the source, NOT inverts the passed operand
  assign src_inv = (uop.alu_op == ALU_SUB) || (uop.opcode == OP_NOT);

  exec_alu i_exec_alu (
    .alu_op      (uop.alu_op),
    .use_carry   (uop.use_carry),
    .src_inv     (src_inv),
    .src_inc     (uop.src_inc),
    .clear_cf_of (uop.clear_cf_of),
    .flags_in    (iss_data.eflags),
    .a           (alu_a),
    .b           (alu_b),
    .result      (alu_result),
    .flags_out   (alu_flags)
  );

  // Every instruction moves EIP, so the CFU always runs
  exec_cfu i_exec_cfu (
    .opcode   (uop.opcode),
    .eflags   (iss_data.eflags),
    .ecx_zero (iss_data.ecx_zero),
    .eip      (iss_data.eip),
    .ilen     (iss_data.ilen),
    .target   (iss_data.opnd0_r),
    .next_eip (next_eip)
  );

  // Move path
  always_comb begin
    if (uop.zext) begin
      mv_opnd0 = {24'h0, iss_data.opnd1_r[7:0]};
    end else if (uop.sext) begin
      mv_opnd0 = {{24{iss_data.opnd1_r[7]}}, iss_data.opnd1_r[7:0]};
    end else begin
      // MOV and XCHG both take opnd1 whole
      mv_opnd0 = iss_data.opnd1_r;
    end
    // Only XCHG writes the second operand
    mv_opnd1 = uop.swap ? iss_data.opnd0_r : iss_data.opnd1_r;
  end

  // Meta path on CF and DF
  always_comb begin
    meta_eflags = iss_data.eflags;
    case (uop.opcode)
      OP_STC:  meta_eflags[FLAG_CF] = 1'b1;
      OP_CLC:  meta_eflags[FLAG_CF] = 1'b0;
      OP_STD:  meta_eflags[FLAG_DF] = 1'b1;
      OP_CLD:  meta_eflags[FLAG_DF] = 1'b0;
      default: ;
    endcase
  end

  // Write operand and EFLAGS selection, inputs pass through by default
  always_comb begin
    opnd0_w  = iss_data.opnd0_r;
    opnd1_w  = iss_data.opnd1_r;
    eflags_w = iss_data.eflags;
    case (uop.unit)
      UNIT_ALU: begin
        // Stack pointer goes back through opnd1 and opnd0 keeps the popped value
        if (uop.stack_adjust) begin
          opnd1_w = alu_result;
        end else if (!uop.no_wr) begin
          opnd0_w = alu_result;
        end
        if (!uop.no_flags) begin
          eflags_w = alu_flags;
        end
      end
      UNIT_MOVE: begin
        opnd0_w = mv_opnd0;
        opnd1_w = mv_opnd1;
      end
      UNIT_META: eflags_w = meta_eflags;
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      ex_valid <= 1'b0;
    end else begin
      ex_valid <= iss_valid;
    end
  end

  // Result payload with its tag
  always_ff @(posedge clk) begin
    if (iss_valid) begin
      ex_res.tag      <= uop.tag;
      ex_res.opnd0_w  <= opnd0_w;
      ex_res.opnd1_w  <= opnd1_w;
      ex_res.eflags   <= eflags_w;
      ex_res.next_eip <= next_eip;
    end
  end

endmodule

// ==== tb_clk_gen.sv ====
module tb_clk_gen #(
  parameter int PERIOD_NS  = 8,
  parameter int RST_CYCLES = 5
) (
  output logic clk,
  output logic arst_n
);
  timeunit 1ns;
  timeprecision 100ps;

  initial begin
    clk = 1'b0;
    forever begin
      #(PERIOD_NS / 2) clk = ~clk;
    end
  end

  // Reset drops before the first edge and lifts on a falling edge
  initial begin
    arst_n = 1'b1;
    #1;
    arst_n = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
  end

endmodule
